// File: Makefile
# Verilator build and run for the load/store unit testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module lsu_tb -Mdir obj_dir -o lsu_sim -f vlog.f

run: compile
	./obj_dir/lsu_sim | tee $(LOG)
	@if grep -qx "TEST RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: sim/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;

  localparam int sweep_requests     = 15 + 4 * 29;
  localparam int neighbor_requests  = 8 * 5;
  localparam int misalign_requests  = 8 * 4;
  localparam int random_requests    = 100;
  localparam int b2b_requests       = 20;
  localparam int total_requests     = sweep_requests + neighbor_requests + misalign_requests +
                                      random_requests + b2b_requests;
  localparam int timeout_cycles     = 4 * total_requests + 100;

  logic                     clk;
  logic                     rst_n;
  logic                     req_valid;
  lsu_pkg::memop_t          req_op;
  logic [lsu_pkg::xlen-1:0] req_addr;
  logic [lsu_pkg::xlen-1:0] req_wdata;
  logic                     req_ready;
  logic                     resp_valid;
  logic [lsu_pkg::xlen-1:0] resp_rdata;
  logic                     resp_err;
  logic                     resp_ready;

  logic [7:0]  mem_model [lsu_pkg::mem_words * lsu_pkg::lane_count];
  logic [64:0] exp_q [$];                                 // {err, rdata} per accepted request
  logic [64:0] head_exp;
  logic        head_valid;
  logic [63:0] mon_rdata;
  logic        mon_err;
  logic [15:0] lfsr_state = 16'd12;
  logic [15:0] stall_state = 16'd12;
  logic        stall_en;
  int          accepted;
  int          cycle;
  int          errors;
  int          passed;
  int          failed;
  int          last_accept;

  lsu_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_err   (resp_err),
    .resp_ready (resp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic void report_fail(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    errors++;
  endfunction

  function automatic int op_bytes(input lsu_pkg::memop_t op);
    case (op)
      lsu_pkg::memop_lb, lsu_pkg::memop_lbu, lsu_pkg::memop_sb: return 1;
      lsu_pkg::memop_lh, lsu_pkg::memop_lhu, lsu_pkg::memop_sh: return 2;
      lsu_pkg::memop_lw, lsu_pkg::memop_lwu, lsu_pkg::memop_sw: return 4;
      default:                                                  return 8;
    endcase
  endfunction

  // Little-endian reference memory access
  function automatic void model_access(input lsu_pkg::memop_t op, input logic [63:0] addr,
                                       input logic [63:0] wdata, output logic [63:0] rdata,
                                       output logic err);
    int   nbytes;
    int   base;
    logic load;
    logic zext;
    nbytes = op_bytes(op);
    base   = int'(addr[10:0]);
    load   = !(op inside {lsu_pkg::memop_sb, lsu_pkg::memop_sh, lsu_pkg::memop_sw,
                          lsu_pkg::memop_sd});
    zext   = op inside {lsu_pkg::memop_lbu, lsu_pkg::memop_lhu, lsu_pkg::memop_lwu};
    err    = (int'(addr[2:0]) % nbytes) != 0;
    rdata  = '0;
    if (!err) begin
      for (int i = 0; i < nbytes; i++) begin
        if (load) begin
          rdata[8*i +: 8] = mem_model[base + i];
        end else begin
          mem_model[base + i] = wdata[8*i +: 8];
        end
      end
      if (load && !zext && nbytes < 8) begin
        for (int i = 8 * nbytes; i < 64; i++) begin
          rdata[i] = rdata[8*nbytes-1];
        end
      end
    end
  endfunction

  // One expected entry per accepted request
  always @(posedge clk) begin
    if (rst_n) begin
      if (resp_valid && resp_ready && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (req_valid && req_ready) begin
        model_access(req_op, req_addr, req_wdata, mon_rdata, mon_err);
        exp_q.push_back({mon_err, mon_rdata});
        accepted <= accepted + 1;
      end
      head_valid <= exp_q.size() != 0;
      head_exp   <= (exp_q.size() != 0) ? exp_q[0] : '0;
    end else begin
      head_valid <= 1'b0;
      head_exp   <= '0;
    end
  end

  always @(posedge clk) begin
    if (stall_en) begin
      stall_state = lfsr_step(stall_state);
      resp_ready <= stall_state[0];
    end else begin
      resp_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      $display("ERROR: the run timed out after %0d cycles", cycle);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    accepted == 0 |-> !resp_valid && req_ready)
    else report_fail("response or stall before the first request");

  a_resp_matches: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid |-> head_valid && resp_rdata == head_exp[63:0] && resp_err == head_exp[64])
    else report_fail("response data or error bit differs from the model");

  a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata) && $stable(resp_err))
    else report_fail("response changed during a stall");

  a_stall_blocks: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |-> !req_ready)
    else report_fail("req_ready high during a stall");

  a_one_cycle_latency: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && req_ready |=> resp_valid)
    else report_fail("no response one cycle after the request");

  a_full_rate: assert property (@(posedge clk) disable iff (!rst_n)
    resp_ready |-> req_ready)
    else report_fail("req_ready low while resp_ready is high");

  task automatic send(input lsu_pkg::memop_t op, input logic [63:0] addr,
                      input logic [63:0] wdata);
    req_valid <= 1'b1;
    req_op    <= op;
    req_addr  <= addr;
    req_wdata <= wdata;
    @(posedge clk);
    while (!req_ready) begin
      @(posedge clk);
    end
    last_accept = cycle;
  endtask

  task automatic drain();
    req_valid <= 1'b0;
    @(posedge clk);
    while (resp_valid) begin
      @(posedge clk);
    end
    @(posedge clk);
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      passed++;
      $display("test %s: passed", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // Each store size fills a word, then every load at every aligned offset
  task automatic sweep_sizes();
    logic [63:0] base;
    int          nb;
    for (int s = 0; s < 4; s++) begin
      base = 64'((s + 1) * 8);
      for (int off = 0; off < 8; off += (1 << s)) begin
        send(lsu_pkg::memop_t'(4'(7 + s)), base + 64'(off), rand_bits(64));
      end
      for (int c = 0; c < 7; c++) begin
        nb = op_bytes(lsu_pkg::memop_t'(4'(c)));
        for (int off = 0; off < 8; off += nb) begin
          send(lsu_pkg::memop_t'(4'(c)), base + 64'(off), 64'd0);
        end
      end
    end
    drain();
  endtask

  task automatic check_neighbors();
    logic [63:0] base;
    for (int i = 0; i < 8; i++) begin
      base = rand_bits(8) << 3;
      send(lsu_pkg::memop_sd, base, rand_bits(64));
      send(lsu_pkg::memop_sb, base + rand_bits(3), rand_bits(64));
      send(lsu_pkg::memop_ld, base, 64'd0);
      send(lsu_pkg::memop_sh, base + (rand_bits(2) << 1), rand_bits(64));
      send(lsu_pkg::memop_ld, base, 64'd0);
    end
    drain();
  endtask

  task automatic misaligned_access();
    logic [63:0] base;
    for (int i = 0; i < 8; i++) begin
      base = rand_bits(8) << 3;
      send(lsu_pkg::memop_sd, base, rand_bits(64));
      send(lsu_pkg::memop_t'(4'(8 + rand_bits(2) % 3)), base + ((rand_bits(2) << 1) | 64'd1),
           rand_bits(64));                                // sh, sw or sd at an odd address
      send(lsu_pkg::memop_ld, base, 64'd0);
      send(lsu_pkg::memop_t'(4'(2 + rand_bits(3) % 5)), base + ((rand_bits(2) << 1) | 64'd1),
           64'd0);
    end
    drain();
  endtask

  task automatic random_stalls();
    lsu_pkg::memop_t op;
    logic [63:0]     addr;
    stall_en <= 1'b1;
    for (int i = 0; i < random_requests; i++) begin
      op   = lsu_pkg::memop_t'(4'(rand_bits(4) % 11));
      addr = rand_bits(11);
      if (rand_bits(1) == 64'd1) begin
        addr = addr & ~64'(op_bytes(op) - 1);             // Half of them aligned
      end
      send(op, addr, rand_bits(64));
    end
    drain();
    stall_en <= 1'b0;
    @(posedge clk);
  endtask

  task automatic back_to_back();
    int first_accept;
    send(lsu_pkg::memop_sd, 64'h40, rand_bits(64));
    first_accept = last_accept;
    for (int i = 1; i < b2b_requests; i++) begin
      send(lsu_pkg::memop_t'(4'(rand_bits(3) % 7)), 64'h40, 64'd0);
    end
    assert (last_accept - first_accept == b2b_requests - 1)
      else report_fail("back-to-back requests were not accepted in consecutive cycles");
    drain();
  endtask

  initial begin
    int errs;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_op     = lsu_pkg::memop_lb;
    req_addr   = '0;
    req_wdata  = '0;
    resp_ready = 1'b1;
    stall_en   = 1'b0;
    errors     = 0;
    passed     = 0;
    failed     = 0;
    for (int i = 0; i < lsu_pkg::mem_words * lsu_pkg::lane_count; i++) begin
      mem_model[i] = 8'h00;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    errs = errors;
    repeat (5) @(posedge clk);
    close_test("reset_idle", errs);
    errs = errors;
    sweep_sizes();
    close_test("size_sweep", errs);
    errs = errors;
    check_neighbors();
    close_test("neighbor_bytes", errs);
    errs = errors;
    misaligned_access();
    close_test("misaligned", errs);
    errs = errors;
    random_stalls();
    close_test("random_stalls", errs);
    errs = errors;
    back_to_back();
    close_test("back_to_back", errs);

    $display("tests passed: %0d, tests failed: %0d", passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/byte_lane_ram.sv
`timescale 1ns/100ps
`default_nettype none

module byte_lane_ram (
  input  logic                               clk,
  input  logic                               rd_en,
  input  logic                               we,
  input  logic [lsu_pkg::word_addr_bits-1:0] word,
  input  logic [7:0]                         wbyte,
  output logic [7:0]                         rdata
);

  logic [7:0] mem [lsu_pkg::mem_words];

  initial begin
    for (int i = 0; i < lsu_pkg::mem_words; i++) begin
      mem[i] = 8'h00;
    end
  end

  always @(posedge clk) begin
    if (we) begin
      mem[word] <= wbyte;
    end
  end

  // Holds its value while rd_en is low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= mem[word];
    end
  end

endmodule

`default_nettype wire

// File: src/lsu_load_format.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_load_format (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  accept,
  input  logic                                  fmt_load,
  input  lsu_pkg::size_t                        fmt_size,
  input  logic                                  fmt_unsigned,
  input  logic [lsu_pkg::lane_offset_bits-1:0]  fmt_offset,
  input  logic                                  fmt_err,
  input  logic [lsu_pkg::lane_count-1:0][7:0]   lane_rdata,
  input  logic                                  resp_ready,
  output logic                                  slot_free,
  output logic                                  resp_valid,
  output logic [lsu_pkg::xlen-1:0]              resp_rdata,
  output logic                                  resp_err
);

  logic                                  load_q;
  lsu_pkg::size_t                        size_q;
  logic                                  unsigned_q;
  logic [lsu_pkg::lane_offset_bits-1:0]  offset_q;
  logic                                  err_q;
  logic [2*lsu_pkg::xlen-1:0]            doubled;
  logic [lsu_pkg::xlen-1:0]              rotated;
  logic [lsu_pkg::xlen-1:0]              extended;
  logic                                  sign;

  assign slot_free = !resp_valid || resp_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (accept) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      load_q     <= fmt_load;
      size_q     <= fmt_size;
      unsigned_q <= fmt_unsigned;
      offset_q   <= fmt_offset;
      err_q      <= fmt_err;
    end
  end

  // Addressed byte moves down to lane 0
  assign doubled = {lane_rdata, lane_rdata};
  assign rotated = doubled[{offset_q, 3'b000} +: lsu_pkg::xlen];

  always_comb begin
    case (size_q)
      lsu_pkg::size_byte: begin
        sign     = !unsigned_q && rotated[7];
        extended = {{(lsu_pkg::xlen-8){sign}}, rotated[7:0]};
      end
      lsu_pkg::size_half: begin
        sign     = !unsigned_q && rotated[15];
        extended = {{(lsu_pkg::xlen-16){sign}}, rotated[15:0]};
      end
      lsu_pkg::size_word: begin
        sign     = !unsigned_q && rotated[31];
        extended = {{(lsu_pkg::xlen-32){sign}}, rotated[31:0]};
      end
      default: begin
        sign     = 1'b0;                                  // Full width needs no extension
        extended = rotated;
      end
    endcase
  end

  assign resp_rdata = (load_q && !err_q) ? extended : '0;  // Stores and errors read zero
  assign resp_err   = err_q;

endmodule

`default_nettype wire

// File: src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int unsigned xlen = 64;
  localparam int unsigned lane_count = xlen / 8;          // One lane per byte
  localparam int unsigned lane_offset_bits = $clog2(lane_count);
  localparam int unsigned mem_words = 256;
  localparam int unsigned word_addr_bits = $clog2(mem_words);

  // Load/store operation codes from the decode stage
  typedef enum logic [3:0] {
    memop_lb  = 4'h0,
    memop_lbu = 4'h1,
    memop_lh  = 4'h2,
    memop_lhu = 4'h3,
    memop_lw  = 4'h4,
    memop_lwu = 4'h5,
    memop_ld  = 4'h6,
    memop_sb  = 4'h7,
    memop_sh  = 4'h8,
    memop_sw  = 4'h9,
    memop_sd  = 4'ha
  } memop_t;

  // log2 of the access width in bytes
  typedef enum logic [1:0] {
    size_byte  = 2'd0,
    size_half  = 2'd1,
    size_word  = 2'd2,
    size_dword = 2'd3
  } size_t;

endpackage

`default_nettype wire

// File: src/lsu_req_align.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_req_align (
  input  logic                                       req_valid,
  input  lsu_pkg::memop_t                            req_op,
  input  logic [lsu_pkg::xlen-1:0]                   req_addr,
  input  logic [lsu_pkg::xlen-1:0]                   req_wdata,
  input  logic                                       slot_free,
  output logic                                       req_ready,
  output logic                                       accept,
  output logic                                       lane_rd_en,
  output logic [lsu_pkg::lane_count-1:0]             lane_we,
  output logic [lsu_pkg::lane_count-1:0][7:0]        lane_wbyte,
  output logic [lsu_pkg::word_addr_bits-1:0]         lane_word,
  output logic                                       fmt_load,
  output lsu_pkg::size_t                             fmt_size,
  output logic                                       fmt_unsigned,
  output logic [lsu_pkg::lane_offset_bits-1:0]       fmt_offset,
  output logic                                       fmt_err
);

  logic                                  is_load;
  logic                                  is_store;
  logic                                  is_unsigned;
  lsu_pkg::size_t                        size;
  logic [lsu_pkg::lane_offset_bits-1:0]  offset;
  logic                                  misaligned;
  logic [lsu_pkg::lane_count-1:0]        size_mask;
  logic [lsu_pkg::xlen-1:0]              wdata_shifted;

  assign offset = req_addr[lsu_pkg::lane_offset_bits-1:0];

  always_comb begin
    is_load     = 1'b0;
    is_store    = 1'b0;
    is_unsigned = 1'b0;
    size        = lsu_pkg::size_byte;
    case (req_op)
      lsu_pkg::memop_lb:  is_load = 1'b1;
      lsu_pkg::memop_lbu: begin is_load = 1'b1; is_unsigned = 1'b1; end
      lsu_pkg::memop_lh:  begin is_load = 1'b1; size = lsu_pkg::size_half; end
      lsu_pkg::memop_lhu: begin
        is_load     = 1'b1;
        is_unsigned = 1'b1;
        size        = lsu_pkg::size_half;
      end
      lsu_pkg::memop_lw:  begin is_load = 1'b1; size = lsu_pkg::size_word; end
      lsu_pkg::memop_lwu: begin
        is_load     = 1'b1;
        is_unsigned = 1'b1;
        size        = lsu_pkg::size_word;
      end
      lsu_pkg::memop_ld:  begin is_load = 1'b1; size = lsu_pkg::size_dword; end
      lsu_pkg::memop_sb:  is_store = 1'b1;
      lsu_pkg::memop_sh:  begin is_store = 1'b1; size = lsu_pkg::size_half; end
      lsu_pkg::memop_sw:  begin is_store = 1'b1; size = lsu_pkg::size_word; end
      lsu_pkg::memop_sd:  begin is_store = 1'b1; size = lsu_pkg::size_dword; end
      default: ;                                          // Unused code makes no access
    endcase
  end

  always_comb begin
    case (size)
      lsu_pkg::size_byte: begin misaligned = 1'b0;          size_mask = 8'b0000_0001; end
      lsu_pkg::size_half: begin misaligned = offset[0];     size_mask = 8'b0000_0011; end
      lsu_pkg::size_word: begin misaligned = |offset[1:0];  size_mask = 8'b0000_1111; end
      default:            begin misaligned = |offset;       size_mask = 8'b1111_1111; end
    endcase
  end

  assign req_ready = slot_free;
  assign accept    = req_valid && slot_free;

  // Store bytes land in lanes starting at the offset
  assign wdata_shifted = req_wdata << {offset, 3'b000};
  assign lane_wbyte    = wdata_shifted;
  assign lane_word     = req_addr[lsu_pkg::lane_offset_bits +: lsu_pkg::word_addr_bits];

  assign lane_rd_en = accept && is_load && !misaligned;
  assign lane_we    = (accept && is_store && !misaligned) ? (size_mask << offset) : '0;

  assign fmt_load     = is_load;
  assign fmt_size     = size;
  assign fmt_unsigned = is_unsigned;
  assign fmt_offset   = offset;
  assign fmt_err      = misaligned;

endmodule

`default_nettype wire

// File: src/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_valid,
  input  lsu_pkg::memop_t          req_op,
  input  logic [lsu_pkg::xlen-1:0] req_addr,
  input  logic [lsu_pkg::xlen-1:0] req_wdata,
  output logic                     req_ready,
  output logic                     resp_valid,
  output logic [lsu_pkg::xlen-1:0] resp_rdata,
  output logic                     resp_err,
  input  logic                     resp_ready
);

  logic                                  slot_free;
  logic                                  accept;
  logic                                  lane_rd_en;
  logic [lsu_pkg::lane_count-1:0]        lane_we;
  logic [lsu_pkg::lane_count-1:0][7:0]   lane_wbyte;
  logic [lsu_pkg::lane_count-1:0][7:0]   lane_rdata;
  logic [lsu_pkg::word_addr_bits-1:0]    lane_word;
  logic                                  fmt_load;
  lsu_pkg::size_t                        fmt_size;
  logic                                  fmt_unsigned;
  logic [lsu_pkg::lane_offset_bits-1:0]  fmt_offset;
  logic                                  fmt_err;

  lsu_req_align u_align (
    .req_valid    (req_valid),
    .req_op       (req_op),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .slot_free    (slot_free),
    .req_ready    (req_ready),
    .accept       (accept),
    .lane_rd_en   (lane_rd_en),
    .lane_we      (lane_we),
    .lane_wbyte   (lane_wbyte),
    .lane_word    (lane_word),
    .fmt_load     (fmt_load),
    .fmt_size     (fmt_size),
    .fmt_unsigned (fmt_unsigned),
    .fmt_offset   (fmt_offset),
    .fmt_err      (fmt_err)
  );

  for (genvar i = 0; i < lsu_pkg::lane_count; i++) begin : lanes_g
    byte_lane_ram u_ram (
      .clk   (clk),
      .rd_en (lane_rd_en),
      .we    (lane_we[i]),
      .word  (lane_word),
      .wbyte (lane_wbyte[i]),
      .rdata (lane_rdata[i])
    );
  end

  lsu_load_format u_format (
    .clk          (clk),
    .rst_n        (rst_n),
    .accept       (accept),
    .fmt_load     (fmt_load),
    .fmt_size     (fmt_size),
    .fmt_unsigned (fmt_unsigned),
    .fmt_offset   (fmt_offset),
    .fmt_err      (fmt_err),
    .lane_rdata   (lane_rdata),
    .resp_ready   (resp_ready),
    .slot_free    (slot_free),
    .resp_valid   (resp_valid),
    .resp_rdata   (resp_rdata),
    .resp_err     (resp_err)
  );

endmodule

`default_nettype wire

// File: vlog.f
src/lsu_pkg.sv
src/lsu_req_align.sv
src/byte_lane_ram.sv
src/lsu_load_format.sv
src/lsu_top.sv
sim/lsu_tb.sv
